// File: logic/daq_tx_pkg.sv
`default_nettype none

package daq_tx_pkg;

	//////////////////////////////
	// Word types
	//////////////////////////////

	typedef logic [15:0] word_t;   // One line word, low byte sent first
	typedef logic [1:0]  kflag_t;  // Per byte K flag, bit 0 for low byte
	typedef logic [31:0] crc_t;    // Running CRC register

	//////////////////////////////
	// 8b10b octets
	//////////////////////////////

	localparam logic [7:0] K28_5    = 8'hBC;  // Comma for idle
	localparam logic [7:0] D16_2    = 8'h50;  // Second idle octet
	localparam logic [7:0] K27_7    = 8'hFB;  // /S/ start of packet
	localparam logic [7:0] K29_7    = 8'hFD;  // /T/ end of packet
	localparam logic [7:0] K23_7    = 8'hF7;  // /R/ carrier extend
	localparam logic [7:0] PRMBL    = 8'h55;  // Preamble octet
	localparam logic [7:0] SOF_BYTE = 8'hD5;  // Start of frame delimiter

	// Constant words, high octet on the left
	localparam word_t IDLE_WORD = {D16_2, K28_5};     // /I2/ ordered set
	localparam word_t SOP_WORD  = {PRMBL, K27_7};     // SOP plus first preamble
	localparam word_t PRE_WORD  = {PRMBL, PRMBL};
	localparam word_t SOF_WORD  = {SOF_BYTE, PRMBL};  // Last preamble plus SFD
	localparam word_t EOP_WORD  = {K23_7, K29_7};     // EOP plus carrier extend
	localparam word_t EXT_WORD  = {K23_7, K23_7};

	localparam kflag_t K_IDLE = 2'b01;
	localparam kflag_t K_NONE = 2'b00;  // Data, CRC and preamble
	localparam kflag_t K_BOTH = 2'b11;

	//////////////////////////////
	// Enums
	//////////////////////////////

	typedef enum logic [2:0] {
		SYM_IDLE,
		SYM_SOP,
		SYM_PRE,
		SYM_SOF,
		SYM_EOP,
		SYM_EXT
	} sym_t;

	typedef enum logic [1:0] {
		SRC_ROM,
		SRC_DATA,
		SRC_CRC_LO,
		SRC_CRC_HI
	} tx_src_t;

	// Low CRC half goes out on the first low valid cycle in ST_DATA
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_SOP,
		ST_PRE,
		ST_SOF,
		ST_DATA,
		ST_CRC_HI,
		ST_EOP,
		ST_EXT,
		ST_GAP
	} frame_state_t;

endpackage

`default_nettype wire

// File: logic/frame_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module frame_seq_fsm
(
	input  wire                   usr_clk_wordwise,
	input  wire                   arst,
	input  wire                   txd_vld_i,       // Source has data
	input  wire                   tmr_done_i,      // Last preamble or gap cycle
	output daq_tx_pkg::sym_t      sym_sel_o,       // ROM entry for this slot
	output daq_tx_pkg::tx_src_t   src_sel_o,       // Word source for this slot
	output logic                  crc_clr_o,
	output logic                  crc_calc_o,
	output logic                  tmr_load_pre_o,
	output logic                  tmr_load_gap_o,
	output logic                  tx_ack_o         // One cycle, data starts next
);

	daq_tx_pkg::frame_state_t state_q;
	daq_tx_pkg::frame_state_t state_d;

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			state_q <= daq_tx_pkg::ST_IDLE;
		else
			state_q <= state_d;
	end

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb
	begin
		state_d = state_q;  // Hold by default
		case (state_q)
			daq_tx_pkg::ST_IDLE:   if (txd_vld_i) state_d = daq_tx_pkg::ST_SOP;
			daq_tx_pkg::ST_SOP:    state_d = daq_tx_pkg::ST_PRE;
			daq_tx_pkg::ST_PRE:    if (tmr_done_i) state_d = daq_tx_pkg::ST_SOF;
			daq_tx_pkg::ST_SOF:    state_d = daq_tx_pkg::ST_DATA;
			daq_tx_pkg::ST_DATA:   if (!txd_vld_i) state_d = daq_tx_pkg::ST_CRC_HI;
			daq_tx_pkg::ST_CRC_HI: state_d = daq_tx_pkg::ST_EOP;
			daq_tx_pkg::ST_EOP:    state_d = daq_tx_pkg::ST_EXT;
			daq_tx_pkg::ST_EXT:    state_d = daq_tx_pkg::ST_GAP;
			daq_tx_pkg::ST_GAP:    if (tmr_done_i) state_d = daq_tx_pkg::ST_IDLE;
			default:               state_d = daq_tx_pkg::ST_IDLE;
		endcase
	end

	//////////////////////////////
	// Per state outputs
	//////////////////////////////

	always_comb
	begin
		sym_sel_o      = daq_tx_pkg::SYM_IDLE;
		src_sel_o      = daq_tx_pkg::SRC_ROM;
		crc_clr_o      = 1'b0;
		crc_calc_o     = 1'b0;
		tmr_load_pre_o = 1'b0;
		tmr_load_gap_o = 1'b0;
		tx_ack_o       = 1'b0;
		case (state_q)
			daq_tx_pkg::ST_SOP:
			begin
				sym_sel_o      = daq_tx_pkg::SYM_SOP;
				tmr_load_pre_o = 1'b1;  // Timer starts with first PRE cycle
			end
			daq_tx_pkg::ST_PRE:
				sym_sel_o = daq_tx_pkg::SYM_PRE;
			daq_tx_pkg::ST_SOF:
			begin
				sym_sel_o = daq_tx_pkg::SYM_SOF;
				crc_clr_o = 1'b1;  // Fresh CRC for this frame
				tx_ack_o  = 1'b1;
			end
			daq_tx_pkg::ST_DATA:
			begin
				if (txd_vld_i)
				begin
					src_sel_o  = daq_tx_pkg::SRC_DATA;
					crc_calc_o = 1'b1;
				end
				else
					src_sel_o = daq_tx_pkg::SRC_CRC_LO;  // Valid dropped, close frame
			end
			daq_tx_pkg::ST_CRC_HI:
				src_sel_o = daq_tx_pkg::SRC_CRC_HI;
			daq_tx_pkg::ST_EOP:
				sym_sel_o = daq_tx_pkg::SYM_EOP;
			daq_tx_pkg::ST_EXT:
			begin
				sym_sel_o      = daq_tx_pkg::SYM_EXT;
				tmr_load_gap_o = 1'b1;  // Gap counted from next cycle
			end
			default:
				sym_sel_o = daq_tx_pkg::SYM_IDLE;  // Idle and gap
		endcase
	end

endmodule

`default_nettype wire

// File: logic/frame_word_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_word_timer #(
	parameter int unsigned PREAMBLE_WORDS = 2,  // 1 to 15
	parameter int unsigned IPG_WORDS      = 4   // 1 to 15
)
(
	input  wire  usr_clk_wordwise,
	input  wire  arst,
	input  wire  load_pre_i,  // Start a preamble count
	input  wire  load_gap_i,  // Start an inter-packet gap count
	output logic done_o       // Last counted cycle
);

	// Loaded with length minus one so zero marks the last cycle
	localparam logic [3:0] PRE_LOAD = 4'(PREAMBLE_WORDS - 1);
	localparam logic [3:0] GAP_LOAD = 4'(IPG_WORDS - 1);

	logic [3:0] cnt_q;
	logic       run_q;  // Count in progress

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			cnt_q <= 4'd0;
			run_q <= 1'b0;
		end
		else if (load_pre_i)
		begin
			cnt_q <= PRE_LOAD;
			run_q <= 1'b1;
		end
		else if (load_gap_i)
		begin
			cnt_q <= GAP_LOAD;
			run_q <= 1'b1;
		end
		else if (run_q)
		begin
			if (cnt_q == 4'd0)
				run_q <= 1'b0;  // Expired, wait for next load
			else
				cnt_q <= cnt_q - 4'd1;
		end
	end

	assign done_o = run_q && (cnt_q == 4'd0);

endmodule

`default_nettype wire

// File: logic/frame_sym_rom.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sym_rom
(
	input  wire                  usr_clk_wordwise,
	input  daq_tx_pkg::sym_t     sym_i,   // Entry to fetch
	output daq_tx_pkg::word_t    word_o,  // Constant word, one cycle later
	output daq_tx_pkg::kflag_t   k_o      // Matching K flags
);

	//////////////////////////////
	// Word and K table
	//////////////////////////////

	always_ff @(posedge usr_clk_wordwise)
	begin
		case (sym_i)
			daq_tx_pkg::SYM_SOP:
			begin
				word_o <= daq_tx_pkg::SOP_WORD;
				k_o    <= daq_tx_pkg::K_IDLE;  // Only /S/ in low byte
			end
			daq_tx_pkg::SYM_PRE:
			begin
				word_o <= daq_tx_pkg::PRE_WORD;
				k_o    <= daq_tx_pkg::K_NONE;
			end
			daq_tx_pkg::SYM_SOF:
			begin
				word_o <= daq_tx_pkg::SOF_WORD;
				k_o    <= daq_tx_pkg::K_NONE;
			end
			daq_tx_pkg::SYM_EOP:
			begin
				word_o <= daq_tx_pkg::EOP_WORD;
				k_o    <= daq_tx_pkg::K_BOTH;
			end
			daq_tx_pkg::SYM_EXT:
			begin
				word_o <= daq_tx_pkg::EXT_WORD;
				k_o    <= daq_tx_pkg::K_BOTH;
			end
			default:
			begin
				word_o <= daq_tx_pkg::IDLE_WORD;  // Idle and unused codes
				k_o    <= daq_tx_pkg::K_IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/crc32_word.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_word
(
	input  wire                 usr_clk_wordwise,
	input  wire                 arst,
	input  wire                 clr_i,     // Preset to all ones
	input  wire                 calc_i,    // Fold d_i into the CRC
	input  daq_tx_pkg::word_t   d_i,       // Two data bytes, low byte first
	output daq_tx_pkg::word_t   crc_lo_o,  // Complemented CRC bits 15:0
	output daq_tx_pkg::word_t   crc_hi_o   // Complemented CRC bits 31:16
);

	// Reflected form of 0x04C11DB7
	localparam daq_tx_pkg::crc_t POLY_REFL = 32'hEDB88320;

	daq_tx_pkg::crc_t crc_q;

	//////////////////////////////
	// Sixteen bit serial step
	//////////////////////////////

	// Bits go in LSB first, so bit 0 of the low byte leads
	function automatic daq_tx_pkg::crc_t crc_step(
		input daq_tx_pkg::crc_t c_in,
		input daq_tx_pkg::word_t d
	);
		daq_tx_pkg::crc_t c;
		logic             fb;
		c = c_in;
		for (int i = 0; i < 16; i++)
		begin
			fb = c[0] ^ d[i];
			c  = c >> 1;
			if (fb)
				c = c ^ POLY_REFL;
		end
		return c;
	endfunction

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			crc_q <= '1;
		else if (clr_i)
			crc_q <= '1;  // Ethernet seed
		else if (calc_i)
			crc_q <= crc_step(crc_q, d_i);
	end

	// Final complement, low half goes on the line first
	assign crc_lo_o = ~crc_q[15:0];
	assign crc_hi_o = ~crc_q[31:16];

endmodule

`default_nettype wire

// File: logic/tx_word_mux.sv
`timescale 1ns/1ps
`default_nettype none

module tx_word_mux
(
	input  wire                   usr_clk_wordwise,
	input  wire                   arst,
	input  daq_tx_pkg::word_t     rom_word_i,    // Already one cycle behind sym_sel
	input  daq_tx_pkg::kflag_t    rom_k_i,
	input  daq_tx_pkg::word_t     txd_i,         // Source data, same cycle as src_sel_i
	input  daq_tx_pkg::tx_src_t   src_sel_i,
	input  daq_tx_pkg::word_t     crc_lo_i,
	input  daq_tx_pkg::word_t     crc_hi_i,
	output daq_tx_pkg::word_t     tx_data_o,     // To the 8b10b encoder
	output daq_tx_pkg::kflag_t    tx_charisk_o
);

	daq_tx_pkg::tx_src_t src_d;  // Select aligned with ROM output
	daq_tx_pkg::word_t   txd_d;  // Data aligned with ROM output

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			src_d <= daq_tx_pkg::SRC_ROM;
		else
			src_d <= src_sel_i;
	end

	always_ff @(posedge usr_clk_wordwise)
	begin
		txd_d <= txd_i;
	end

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			tx_data_o    <= daq_tx_pkg::IDLE_WORD;  // Line idles out of reset
			tx_charisk_o <= daq_tx_pkg::K_IDLE;
		end
		else
		begin
			case (src_d)
				daq_tx_pkg::SRC_DATA:   tx_data_o <= txd_d;
				daq_tx_pkg::SRC_CRC_LO: tx_data_o <= crc_lo_i;  // CRC still stable here
				daq_tx_pkg::SRC_CRC_HI: tx_data_o <= crc_hi_i;
				default:                tx_data_o <= rom_word_i;
			endcase
			if (src_d == daq_tx_pkg::SRC_ROM)
				tx_charisk_o <= rom_k_i;
			else
				tx_charisk_o <= daq_tx_pkg::K_NONE;  // Payload never carries K codes
		end
	end

endmodule

`default_nettype wire

// File: logic/daq_frame_tx.sv
`timescale 1ns/1ps
`default_nettype none

module daq_frame_tx #(
	parameter int unsigned PREAMBLE_WORDS = 2,  // PRE words after SOP
	parameter int unsigned IPG_WORDS      = 4   // Minimum idle words between packets
)
(
	input  wire                  usr_clk_wordwise,
	input  wire                  arst,
	input  daq_tx_pkg::word_t    txd_i,         // Data to send
	input  wire                  txd_vld_i,     // Level, starts a packet
	output logic                 tx_ack_o,      // Data flow starts next cycle
	output daq_tx_pkg::word_t    tx_data_o,
	output daq_tx_pkg::kflag_t   tx_charisk_o
);

	daq_tx_pkg::sym_t    sym_sel;
	daq_tx_pkg::tx_src_t src_sel;
	logic                crc_clr;
	logic                crc_calc;
	logic                tmr_load_pre;
	logic                tmr_load_gap;
	logic                tmr_done;
	daq_tx_pkg::word_t   rom_word;
	daq_tx_pkg::kflag_t  rom_k;
	daq_tx_pkg::word_t   crc_lo;
	daq_tx_pkg::word_t   crc_hi;

	//////////////////////////////
	// Control
	//////////////////////////////

	frame_seq_fsm frame_seq_fsm_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_vld_i        (txd_vld_i),
		.tmr_done_i       (tmr_done),
		.sym_sel_o        (sym_sel),
		.src_sel_o        (src_sel),
		.crc_clr_o        (crc_clr),
		.crc_calc_o       (crc_calc),
		.tmr_load_pre_o   (tmr_load_pre),
		.tmr_load_gap_o   (tmr_load_gap),
		.tx_ack_o         (tx_ack_o)
	);

	frame_word_timer #(
		.PREAMBLE_WORDS (PREAMBLE_WORDS),
		.IPG_WORDS      (IPG_WORDS)
	) frame_word_timer_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.load_pre_i       (tmr_load_pre),
		.load_gap_i       (tmr_load_gap),
		.done_o           (tmr_done)
	);

	//////////////////////////////
	// Word path
	//////////////////////////////

	frame_sym_rom frame_sym_rom_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.sym_i            (sym_sel),
		.word_o           (rom_word),
		.k_o              (rom_k)
	);

	crc32_word crc32_word_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.clr_i            (crc_clr),
		.calc_i           (crc_calc),
		.d_i              (txd_i),
		.crc_lo_o         (crc_lo),
		.crc_hi_o         (crc_hi)
	);

	tx_word_mux tx_word_mux_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.rom_word_i       (rom_word),
		.rom_k_i          (rom_k),
		.txd_i            (txd_i),
		.src_sel_i        (src_sel),
		.crc_lo_i         (crc_lo),
		.crc_hi_i         (crc_hi),
		.tx_data_o        (tx_data_o),
		.tx_charisk_o     (tx_charisk_o)
	);

endmodule

`default_nettype wire

// File: sim/tb_daq_frame_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_daq_frame_tx;

	localparam int unsigned PRE_N   = 2;
	localparam int unsigned GAP_N   = 4;
	localparam int unsigned N_RAND  = 8;   // Random length packets
	localparam int unsigned MAX_LEN = 40;
	localparam int unsigned N_PKTS  = N_RAND + 4;  // Plus single, pair and vector
	localparam int unsigned PKT_OVH = 6 + PRE_N + GAP_N + 8;  // Framing, gap, pipeline
	localparam int unsigned TIMEOUT_NS = (18 + N_PKTS * (MAX_LEN + PKT_OVH)) * 4 + 400;

	// {K flags, word} as seen on the line
	localparam logic [17:0] W_IDLE = {2'b01, 16'h50BC};
	localparam logic [17:0] W_SOP  = {2'b01, 16'h55FB};
	localparam logic [17:0] W_PRE  = {2'b00, 16'h5555};
	localparam logic [17:0] W_SOF  = {2'b00, 16'hD555};
	localparam logic [17:0] W_EOP  = {2'b11, 16'hF7FD};
	localparam logic [17:0] W_EXT  = {2'b11, 16'hF7F7};

	logic        usr_clk_wordwise;
	logic        arst;
	logic [15:0] txd_i;
	logic        txd_vld_i;
	logic        tx_ack_o;
	logic [15:0] tx_data_o;
	logic [1:0]  tx_charisk_o;

	int          err_cnt   = 0;
	int          chk_cnt   = 0;
	int          ack_cnt   = 0;  // Ack cycles seen by the monitor
	int          pkt_done  = 0;  // Packets closed by EXT
	int          pkt_sent  = 0;
	logic [31:0] lfsr      = 32'h1f0e;
	logic [15:0] pkt_q[$];       // Data words of the packet being built
	logic [17:0] exp_q[$];
	int          exp_len_q[$];
	logic [17:0] got_q[$];
	int          got_len_q[$];

	initial usr_clk_wordwise = 1'b0;
	always #2 usr_clk_wordwise = ~usr_clk_wordwise;  // 4 ns period

	daq_frame_tx #(
		.PREAMBLE_WORDS (PRE_N),
		.IPG_WORDS      (GAP_N)
	) dut0 (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_i            (txd_i),
		.txd_vld_i        (txd_vld_i),
		.tx_ack_o         (tx_ack_o),
		.tx_data_o        (tx_data_o),
		.tx_charisk_o     (tx_charisk_o)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		chk_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("ERR at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			lfsr_next = (s >> 1) ^ 32'h80200003;
		else
			lfsr_next = s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};  // One step per bit
		end
		return v;
	endfunction

	// Table free bytewise CRC-32, reflected
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] r;
		r = c ^ {24'h0, b};
		for (int i = 0; i < 8; i++)
			r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
		return r;
	endfunction

	// Expected line words for pkt_q
	task automatic expect_packet();
		logic [31:0] c;
		c = 32'hFFFFFFFF;
		exp_q.push_back(W_SOP);
		for (int i = 0; i < int'(PRE_N); i++)
			exp_q.push_back(W_PRE);
		exp_q.push_back(W_SOF);
		foreach (pkt_q[i])
		begin
			exp_q.push_back({2'b00, pkt_q[i]});
			c = crc_byte(c, pkt_q[i][7:0]);  // Low byte on the line first
			c = crc_byte(c, pkt_q[i][15:8]);
		end
		c = ~c;
		exp_q.push_back({2'b00, c[15:0]});
		exp_q.push_back({2'b00, c[31:16]});
		exp_q.push_back(W_EOP);
		exp_q.push_back(W_EXT);
		exp_len_q.push_back(pkt_q.size() + int'(PRE_N) + 6);
	endtask

	task automatic random_packet();
		logic [31:0] r;
		int          len;
		pkt_q.delete();
		len = 1 + int'(rand_bits(6) % MAX_LEN);
		for (int i = 0; i < len; i++)
		begin
			r = rand_bits(16);
			pkt_q.push_back(r[15:0]);
		end
	endtask

	// Called on a falling edge; rearm raises valid again right after the drop
	task automatic send_packet(input logic rearm);
		txd_vld_i = 1'b1;
		@(negedge usr_clk_wordwise);
		while (!tx_ack_o)
			@(negedge usr_clk_wordwise);
		foreach (pkt_q[i])
		begin
			@(negedge usr_clk_wordwise);
			check_val(32'(tx_ack_o), 32'd0, "ack longer than one cycle");
			txd_i = pkt_q[i];  // Sampled in ST_DATA
		end
		@(negedge usr_clk_wordwise);
		txd_vld_i = 1'b0;  // Ends the data
		pkt_sent++;
		if (rearm)
		begin
			@(negedge usr_clk_wordwise);
			txd_vld_i = 1'b1;
		end
	endtask

	task automatic compare_packets(input string name);
		int          n_exp;
		int          n_got;
		int          n_max;
		logic [17:0] g;
		logic [17:0] e;
		while (pkt_done < pkt_sent)
			@(negedge usr_clk_wordwise);
		while (exp_len_q.size() > 0)
		begin
			n_exp = exp_len_q.pop_front();
			n_got = got_len_q.pop_front();
			check_val(32'(n_got), 32'(n_exp), $sformatf("%s packet length", name));
			n_max = (n_got > n_exp) ? n_got : n_exp;
			for (int i = 0; i < n_max; i++)
			begin
				g = '0;
				e = '1;
				if (i < n_got)
					g = got_q.pop_front();
				if (i < n_exp)
					e = exp_q.pop_front();
				check_val(32'(g), 32'(e), $sformatf("%s word %0d", name, i));
			end
		end
	endtask

	// Line monitor, idle rules checked between packets
	task automatic watch_line();
		logic [17:0] w;
		logic        capturing;
		logic        seen_pkt;
		int          cap_len;
		int          idle_run;
		capturing = 1'b0;
		seen_pkt  = 1'b0;
		cap_len   = 0;
		idle_run  = 0;
		forever
		begin
			@(negedge usr_clk_wordwise);
			w = {tx_charisk_o, tx_data_o};
			if (tx_ack_o)
				ack_cnt++;
			if (capturing)
			begin
				got_q.push_back(w);
				cap_len++;
				if (w == W_EXT)  // Data never has K flags set
				begin
					capturing = 1'b0;
					got_len_q.push_back(cap_len);
					pkt_done++;
					idle_run = 0;
				end
			end
			else if (w == W_SOP)
			begin
				if (seen_pkt)
					check_val(32'(idle_run >= int'(GAP_N)), 32'd1, "idle words before SOP");
				seen_pkt  = 1'b1;
				capturing = 1'b1;
				cap_len   = 1;
				got_q.push_back(w);
			end
			else
			begin
				check_val(32'(w), 32'(W_IDLE), "idle line");
				idle_run++;
			end
		end
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic test_idle_after_reset();
		for (int i = 0; i < 10; i++)
		begin
			@(negedge usr_clk_wordwise);
			check_val(32'(tx_ack_o), 32'd0, "ack after reset");
			check_val(32'({tx_charisk_o, tx_data_o}), 32'(W_IDLE), "idle after reset");
		end
	endtask

	task automatic test_single_word();
		int acks;
		acks = ack_cnt;
		pkt_q.delete();
		pkt_q.push_back(16'hA5C3);
		expect_packet();
		send_packet(1'b0);
		compare_packets("single");
		check_val(32'(ack_cnt - acks), 32'd1, "ack pulses for single word");
	endtask

	task automatic test_random_packets();
		for (int k = 0; k < int'(N_RAND); k++)
		begin
			random_packet();
			expect_packet();
			send_packet(1'b0);
			compare_packets($sformatf("random %0d", k));
		end
	endtask

	// Valid back high during the gap, next SOP must wait it out
	task automatic test_back_to_back();
		random_packet();
		expect_packet();
		send_packet(1'b1);
		random_packet();
		expect_packet();
		send_packet(1'b0);
		compare_packets("back to back");
	endtask

	// "12345678" two bytes per word, low byte first
	task automatic test_known_vector();
		pkt_q.delete();
		pkt_q.push_back(16'h3231);
		pkt_q.push_back(16'h3433);
		pkt_q.push_back(16'h3635);
		pkt_q.push_back(16'h3837);
		expect_packet();
		// Standard CRC-32 of the string is 9AE0DAAF
		exp_q[exp_q.size() - 4] = {2'b00, 16'hDAAF};
		exp_q[exp_q.size() - 3] = {2'b00, 16'h9AE0};
		send_packet(1'b0);
		compare_packets("known vector");
	endtask

	initial
	begin
		arst      = 1'b1;
		txd_i     = 16'h0;
		txd_vld_i = 1'b0;
		repeat (8) @(posedge usr_clk_wordwise);
		@(negedge usr_clk_wordwise);
		arst = 1'b0;
		fork
			watch_line();
		join_none
		test_idle_after_reset();
		test_single_word();
		test_random_packets();
		test_back_to_back();
		test_known_vector();
		repeat (GAP_N + 4) @(negedge usr_clk_wordwise);  // Let the line settle to idle
		check_val(32'(ack_cnt), 32'(pkt_sent), "total ack pulses");
		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Bound from the worst case packet lengths
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the DUT did not finish its packets in time, %0d errors so far",
			err_cnt);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: daq_frame_tx.f
logic/daq_tx_pkg.sv
logic/frame_seq_fsm.sv
logic/frame_word_timer.sv
logic/frame_sym_rom.sv
logic/crc32_word.sv
logic/tx_word_mux.sv
logic/daq_frame_tx.sv
sim/tb_daq_frame_tx.sv

// File: Makefile
TOP = tb_daq_frame_tx

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f daq_frame_tx.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
